// File: bench/audio_fx_golden.mem
// columns: sel (effect code), audio_in, expected audio_out, all hex
// one accepted sample per line, in the order they are sent
0 25 25
2 30 30 // echo, history still empty
5 9c 9c
6 7f 7f
7 80 80
2 e0 e0
1 7f 6f // tremolo gain 14
1 80 88 // gain 15
1 c9 cc
1 21 1c
3 40 40 // knee
3 41 40
3 7f 5f
3 80 a0
3 bf c0
3 9c ae
2 10 22 // echo, first full history sample
2 70 7f // saturates high
2 90 80 // saturates low
2 00 3f
2 f0 b0
4 20 10 // switch to reverb
4 e0 1f
4 d0 90
4 10 f4
1 c0 c8
1 33 29
0 5a 5a
3 c1 c1
2 11 d1
1 7f 47
1 81 c0
4 40 48
4 00 38
2 00 c8
4 05 05
2 00 f8
4 00 08 // reverb output fed back
2 00 0f
4 40 08

// File: bench/audio_fx_tb.sv
`default_nettype none

module audio_fx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VEC     = 40;                 // lines in the golden file
    localparam int CYCLE_LIMIT = NUM_VEC * 20 + 100; // whole run bound
    localparam int WAIT_LIMIT  = 20;                 // per handshake bound

    logic                  clk;
    logic                  rst;
    audio_fx_pkg::sample_t audio_in;
    audio_fx_pkg::fx_sel_e sel;
    logic                  sample_en;
    logic                  sample_ready;
    audio_fx_pkg::sample_t audio_out;
    logic                  out_valid;

    logic [7:0] golden [0:3*NUM_VEC-1]; // sel, input, expected per vector
    int         value_errors = 0;
    int         other_errors = 0;
    int         cycle_count  = 0;

    audio_fx_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .audio_in     (audio_in),
        .sel          (sel),
        .sample_en    (sample_en),
        .sample_ready (sample_ready),
        .audio_out    (audio_out),
        .out_valid    (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            report_counts();
            $display("Regression failed");
            $finish;
        end
    end

    // one clock and then settle past the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_counts();
        $display("errors: %0d value, %0d protocol, %0d total",
                 value_errors, other_errors, value_errors + other_errors);
    endtask

    task automatic check_sample(input string name, input audio_fx_pkg::sample_t exp,
                                input audio_fx_pkg::sample_t got);
        if (got !== exp) begin
            $display("[FAIL] %t %s expected %h got %h", $time, name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_ready_state(input logic exp_ready, input logic exp_valid);
        if (sample_ready !== exp_ready) begin
            $display("[FAIL] %t sample_ready expected %b got %b",
                     $time, exp_ready, sample_ready);
            value_errors++;
        end
        if (out_valid !== exp_valid) begin
            $display("[FAIL] %t out_valid expected %b got %b", $time, exp_valid, out_valid);
            value_errors++;
        end
    endtask

    task automatic wait_for_ready(input int vec, output bit ok);
        int waited;
        waited = 0;
        while (sample_ready !== 1'b1 && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        ok = (sample_ready === 1'b1);
        if (!ok) begin
            $display("vector %0d skipped, sample_ready stayed low for %0d cycles",
                     vec, WAIT_LIMIT);
            other_errors++;
        end
    endtask

    // busy window until the result pulse
    task automatic wait_for_valid(input int vec, input audio_fx_pkg::sample_t held,
                                  output bit seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            if (out_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_ready_state(1'b0, 1'b0);              // still busy with no result
                check_sample("audio_out", held, audio_out); // old result held
                step();
                waited++;
            end
        end
        if (!seen) begin
            $display("vector %0d got no out_valid pulse within %0d cycles", vec, WAIT_LIMIT);
            other_errors++;
        end
    endtask

    initial begin
        audio_fx_pkg::sample_t exp_out;
        audio_fx_pkg::sample_t last_out;
        bit                    ok;
        int                    i;
        $timeformat(-9, 0, " ns", 0);
        rst       = 1'b1;
        audio_in  = '0;
        sel       = audio_fx_pkg::fx_bypass;
        sample_en = 1'b0;
        $readmemh("bench/audio_fx_golden.mem", golden);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        if ($isunknown(golden[3*NUM_VEC-1])) begin
            $display("golden file is missing or shorter than %0d lines", NUM_VEC);
            other_errors++;
        end
        check_ready_state(1'b1, 1'b0); // idle after reset
        check_sample("audio_out", '0, audio_out);
        last_out = '0;
        for (i = 0; i < NUM_VEC; i++) begin
            exp_out = golden[3*i+2];
            wait_for_ready(i, ok);
            if (ok) begin
                audio_in  = golden[3*i+1];
                sel       = audio_fx_pkg::fx_sel_e'(golden[3*i][2:0]); // 5..7 kept as is
                sample_en = 1'b1;
                step();
                sample_en = 1'b0; // single cycle strobe
                wait_for_valid(i, last_out, ok);
                if (ok) begin
                    check_ready_state(1'b1, 1'b1); // ready returns with valid
                    check_sample("audio_out", exp_out, audio_out);
                    last_out = exp_out;
                end
            end
        end
        step();
        check_ready_state(1'b1, 1'b0); // valid lasted one cycle
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/audio_fx_pkg.sv
rtl/tremolo_mod.sv
rtl/soft_clipper.sv
rtl/delay_line_ctrl.sv
rtl/sample_ram.sv
rtl/audio_fx_top.sv
bench/audio_fx_tb.sv

// File: rtl/audio_fx_macros.svh
`ifndef AFX_MACROS_SVH
`define AFX_MACROS_SVH

// echo and reverb delay, in samples
`define AFX_DELAY_SAMPLES 16

// sample memory address width, 32 entries
`define AFX_ADDR_W 5

// soft clip knee magnitude
`define AFX_CLIP_KNEE 64

// triangle steps per half period of the tremolo
`define AFX_TREM_STEPS 8

// lowest tremolo gain, in sixteenths
`define AFX_TREM_BASE 8

`endif

// File: rtl/audio_fx_pkg.sv
`default_nettype none
`include "audio_fx_macros.svh"

package audio_fx_pkg;

    typedef logic signed [7:0] sample_t; // one mono audio sample

    // effect select codes, 5..7 fall back to bypass
    typedef enum logic [2:0] {
        fx_bypass    = 3'd0,
        fx_tremolo   = 3'd1,
        fx_echo      = 3'd2,
        fx_soft_clip = 3'd3,
        fx_reverb    = 3'd4
    } fx_sel_e;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_e;

    // request word held stable for a whole req/ack cycle
    typedef struct packed {
        mem_op_e                op;    // read or write
        logic [`AFX_ADDR_W-1:0] addr;  // slot in sample memory
        sample_t                wdata; // write payload
    } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/audio_fx_top.sv
`default_nettype none

module audio_fx_top (
    input  logic                  clk,
    input  logic                  rst,
    input  audio_fx_pkg::sample_t audio_in,
    input  audio_fx_pkg::fx_sel_e sel,
    input  logic                  sample_en,
    output logic                  sample_ready,
    output audio_fx_pkg::sample_t audio_out,
    output logic                  out_valid
);

    logic                   accept;    // strobe while ready
    audio_fx_pkg::sample_t  sample_q;
    audio_fx_pkg::fx_sel_e  sel_q;
    audio_fx_pkg::sample_t  trem_out;
    audio_fx_pkg::sample_t  clip_out;
    audio_fx_pkg::sample_t  delay_out;
    audio_fx_pkg::sample_t  result;
    logic                   done;
    audio_fx_pkg::mem_req_t mem_req;
    logic                   req;
    logic                   ack;
    audio_fx_pkg::sample_t  mem_rdata;

    assign accept = sample_en && sample_ready;

    tremolo_mod tremolo_i (
        .clk       (clk),
        .rst       (rst),
        .advance   (accept),   // index steps in every mode
        .audio_in  (sample_q),
        .audio_out (trem_out)
    );

    soft_clipper clipper_i (
        .audio_in  (sample_q),
        .audio_out (clip_out)
    );

    delay_line_ctrl delay_i (
        .clk       (clk),
        .rst       (rst),
        .start     (accept),   // every sample goes through the ring
        .audio_in  (audio_in),
        .reverb    (sel == audio_fx_pkg::fx_reverb),
        .delay_out (delay_out),
        .done      (done),
        .mem_req   (mem_req),
        .req       (req),
        .ack       (ack),
        .mem_rdata (mem_rdata)
    );

    sample_ram ram_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .req       (req),
        .ack       (ack),
        .mem_rdata (mem_rdata)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            sample_q <= audio_in;
            sel_q    <= sel;
        end
    end

    always_comb begin
        case (sel_q)
            audio_fx_pkg::fx_tremolo:   result = trem_out;
            audio_fx_pkg::fx_soft_clip: result = clip_out;
            audio_fx_pkg::fx_echo,
            audio_fx_pkg::fx_reverb:    result = delay_out;
            default:                    result = sample_q; // bypass and spare codes
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_ready <= 1'b1;
            out_valid    <= 1'b0;
            audio_out    <= '0;
        end else begin
            out_valid <= done; // one cycle after done
            if (accept) begin
                sample_ready <= 1'b0; // busy until result
            end
            if (done) begin
                sample_ready <= 1'b1;
                audio_out    <= result; // held until next valid
            end
        end
    end

    strobe_only_when_ready: assert property (@(posedge clk) disable iff (rst)
        sample_en |-> sample_ready);

    valid_single_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid);

endmodule

`default_nettype wire

// File: rtl/delay_line_ctrl.sv
`default_nettype none
`include "audio_fx_macros.svh"

module delay_line_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  audio_fx_pkg::sample_t  audio_in,
    input  logic                   reverb,
    output audio_fx_pkg::sample_t  delay_out,
    output logic                   done,
    output audio_fx_pkg::mem_req_t mem_req,
    output logic                   req,
    input  logic                   ack,
    input  audio_fx_pkg::sample_t  mem_rdata
);

    localparam int unsigned       ADDR_W    = `AFX_ADDR_W;
    localparam logic [ADDR_W-1:0] LAST_SLOT = ADDR_W'(`AFX_DELAY_SAMPLES - 1);
    localparam logic [ADDR_W-1:0] FULL      = ADDR_W'(`AFX_DELAY_SAMPLES);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_req,
        st_rd_rel,
        st_wr_req,
        st_wr_rel,
        st_done
    } state_e;

    state_e                state;
    logic [ADDR_W-1:0]     ptr;      // ring slot, 0..DELAY-1
    logic [ADDR_W-1:0]     fill;     // samples written, saturates at DELAY
    logic                  reverb_q; // mode of the sample in flight
    audio_fx_pkg::sample_t sample_q; // sample in flight
    audio_fx_pkg::sample_t wdata_q;  // value stored back into the ring
    audio_fx_pkg::sample_t delay_q;  // effect result
    audio_fx_pkg::sample_t past;     // sample from DELAY ago
    logic signed [8:0]     sum;
    audio_fx_pkg::sample_t mix;

    always_comb begin
        past = (fill == FULL) ? mem_rdata : '0; // unwritten history is silence
        sum  = {sample_q[7], sample_q} + {past[7], past[7], past[7:1]}; // x + past/2
        if (sum[8] != sum[7]) begin
            mix = sum[8] ? 8'sh80 : 8'sh7f; // clamp to -128 / +127
        end else begin
            mix = sum[7:0];
        end
    end

    always_comb begin
        mem_req.op    = (state == st_wr_req) ? audio_fx_pkg::mem_write : audio_fx_pkg::mem_read;
        mem_req.addr  = ptr;     // same slot for read and write
        mem_req.wdata = wdata_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            req   <= 1'b0;
            ptr   <= '0;
            fill  <= '0;
        end else begin
            case (state)
                st_idle: if (start) begin
                    req   <= 1'b1; // ack is low here
                    state <= st_rd_req;
                end
                st_rd_req: if (ack) begin
                    req   <= 1'b0;
                    state <= st_rd_rel;
                end
                st_rd_rel: if (!ack) begin
                    req   <= 1'b1; // write phase
                    state <= st_wr_req;
                end
                st_wr_req: if (ack) begin
                    req   <= 1'b0;
                    ptr   <= (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
                    if (fill != FULL) begin
                        fill <= fill + 1'b1;
                    end
                    state <= st_wr_rel;
                end
                st_wr_rel: if (!ack) begin
                    state <= st_done; // slave idle again
                end
                default: state <= st_idle; // st_done
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            sample_q <= audio_in;
            reverb_q <= reverb;
        end
        if (state == st_rd_req && ack) begin
            delay_q <= mix;                          // rdata valid with ack
            wdata_q <= reverb_q ? mix : sample_q;    // reverb stores its output
        end
    end

    assign delay_out = delay_q;
    assign done      = (state == st_done);

    // four-phase rule, req only falls after ack was seen
    req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(req) |-> $past(ack));

endmodule

`default_nettype wire

// File: rtl/sample_ram.sv
`default_nettype none
`include "audio_fx_macros.svh"

module sample_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  audio_fx_pkg::mem_req_t mem_req,
    input  logic                   req,
    output logic                   ack,
    output audio_fx_pkg::sample_t  mem_rdata
);

    localparam int DEPTH = 2 ** `AFX_ADDR_W;

    audio_fx_pkg::sample_t mem [DEPTH];
    logic                  take; // new request seen

    assign take = req && !ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack       <= 1'b0;
            mem_rdata <= '0;
        end else if (take) begin
            ack <= 1'b1;
            if (mem_req.op == audio_fx_pkg::mem_read) begin
                mem_rdata <= mem[mem_req.addr]; // valid with ack
            end
        end else if (!req && ack) begin
            ack <= 1'b0; // release phase
        end
    end

    always_ff @(posedge clk) begin
        if (take && mem_req.op == audio_fx_pkg::mem_write) begin
            mem[mem_req.addr] <= mem_req.wdata; // same edge as ack rise
        end
    end

    // master must hold the request word for the whole req high window
    req_word_stable: assert property (@(posedge clk) disable iff (rst)
        req && $past(req) |-> $stable(mem_req));

endmodule

`default_nettype wire

// File: rtl/soft_clipper.sv
`default_nettype none
`include "audio_fx_macros.svh"

module soft_clipper (
    input  audio_fx_pkg::sample_t audio_in,
    output audio_fx_pkg::sample_t audio_out
);

    localparam logic [7:0] KNEE = 8'(`AFX_CLIP_KNEE);

    logic       neg;   // input sign
    logic [7:0] mag;   // |x|, 128 fits unsigned
    logic [7:0] mag_c; // magnitude after the knee

    always_comb begin
        neg = audio_in[7];
        if (neg) begin
            mag = ~audio_in + 8'd1; // -128 gives 128
        end else begin
            mag = audio_in;
        end

        if (mag > KNEE) begin
            mag_c = KNEE + ((mag - KNEE) >> 1); // half slope above knee
        end else begin
            mag_c = mag; // linear region
        end

        // max is 96, the sign restore never overflows
        if (neg) begin
            audio_out = ~mag_c + 8'd1;
        end else begin
            audio_out = mag_c;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tremolo_mod.sv
`default_nettype none
`include "audio_fx_macros.svh"

module tremolo_mod (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  audio_fx_pkg::sample_t audio_in,
    output audio_fx_pkg::sample_t audio_out
);

    logic [3:0]         idx;       // position in 16-sample period
    logic [3:0]         tri_step;  // 0..7 up, 7..0 down
    logic [4:0]         gain_next; // gain for the current index
    logic [4:0]         gain_q;    // gain of the last accepted sample
    logic signed [13:0] prod;

    always_comb begin
        if (idx < 4'(`AFX_TREM_STEPS)) begin
            tri_step = idx; // rising half
        end else begin
            tri_step = 4'(2 * `AFX_TREM_STEPS - 1) - idx; // falling half
        end
        gain_next = 5'(`AFX_TREM_BASE) + {1'b0, tri_step};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx    <= '0;
            gain_q <= 5'(`AFX_TREM_BASE);
        end else if (advance) begin
            idx    <= idx + 4'd1;   // wraps at 16
            gain_q <= gain_next;    // freeze gain before the step
        end
    end

    // sample * gain / 16, floor via arithmetic shift
    assign prod      = audio_in * $signed({1'b0, gain_q});
    assign audio_out = prod[11:4]; // gain <= 15/16 so no overflow

endmodule

`default_nettype wire
